//--- vlog.f
+incdir+common
common/pwo_arith_pkg.sv
common/pwo_mem_pkg.sv
pwo_datapath/pwo_lane.sv
pwo_datapath/pwo_datapath.sv
design/pwo_ctrl.sv
design/pwo_cfg_regs.sv
design/pwo_top.sv
tests/pwo_tb.sv

//--- Bender.yml
package:
  name: pwo

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pwo_arith_pkg.sv
      - common/pwo_mem_pkg.sv
      - pwo_datapath/pwo_lane.sv
      - pwo_datapath/pwo_datapath.sv
      - design/pwo_ctrl.sv
      - design/pwo_cfg_regs.sv
      - design/pwo_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/pwo_tb.sv

//--- tests/pwo_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwo_params.svh"

module pwo_tb;
    import pwo_arith_pkg::*;
    import pwo_mem_pkg::*;

    localparam int     CLK_PERIOD = 20;
    localparam int     NUM_CMDS   = 12;
    localparam int     CMD_CYCLES = 120;
    localparam longint Q          = `PWO_Q;
    // Accepting edge to ack for a command that touches memory
    localparam int     RUN_CYCLES = `PWO_WORDS + `PWO_LAT + 2;

    logic        clk;
    logic        reset_n;
    logic        cmd_req;
    pwo_cmd_t    cmd;
    logic        cmd_ack;
    logic        busy;
    mem_req_t    a_rd_req;
    mem_req_t    b_rd_req;
    mem_req_t    c_rd_req;
    mem_req_t    c_wr_req;
    mem_word_t   a_rd_data;
    mem_word_t   b_rd_data;
    mem_word_t   c_rd_data;
    mem_word_t   c_wr_data;

    mem_word_t   a_mem [mem_addr_t];
    mem_word_t   b_mem [mem_addr_t];
    mem_word_t   c_mem [mem_addr_t];
    mem_addr_t   wr_addr_q [$];
    mem_word_t   wr_data_q [$];
    int          a_rd_cnt;
    int          b_rd_cnt;
    int          c_rd_cnt;
    logic [31:0] rand_state;

    pwo_top pwo_top_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd_req_i   (cmd_req),
        .cmd_i       (cmd),
        .cmd_ack_o   (cmd_ack),
        .busy_o      (busy),
        .a_rd_req_o  (a_rd_req),
        .b_rd_req_o  (b_rd_req),
        .c_rd_req_o  (c_rd_req),
        .c_wr_req_o  (c_wr_req),
        .a_rd_data_i (a_rd_data),
        .b_rd_data_i (b_rd_data),
        .c_rd_data_i (c_rd_data),
        .c_wr_data_o (c_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_CMDS * CMD_CYCLES * CLK_PERIOD);
        $display("Timeout: the commands did not complete within the watchdog limit");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    // ====================
    // Memory models
    // ====================

    // Unwritten words read back as a pattern of the full address
    function automatic mem_word_t fill_word(input mem_addr_t addr);
        mem_word_t w;
        for (int l = 0; l < `PWO_LANES; l++) begin
            w[l] = `PWO_REG_W'({addr, 2'(l)});
        end
        return w;
    endfunction

    // One cycle read latency, every C write is recorded
    always @(posedge clk) begin
        if (c_wr_req.en) begin
            c_mem[c_wr_req.addr] = c_wr_data;
            wr_addr_q.push_back(c_wr_req.addr);
            wr_data_q.push_back(c_wr_data);
        end
        if (a_rd_req.en) begin
            a_rd_cnt++;
            a_rd_data <= a_mem.exists(a_rd_req.addr) ? a_mem[a_rd_req.addr]
                                                     : fill_word(a_rd_req.addr);
        end
        if (b_rd_req.en) begin
            b_rd_cnt++;
            b_rd_data <= b_mem.exists(b_rd_req.addr) ? b_mem[b_rd_req.addr]
                                                     : fill_word(b_rd_req.addr);
        end
        if (c_rd_req.en) begin
            c_rd_cnt++;
            c_rd_data <= c_mem.exists(c_rd_req.addr) ? c_mem[c_rd_req.addr]
                                                     : fill_word(c_rd_req.addr);
        end
    end

    // ====================
    // Stimulus and model
    // ====================

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Mode 0 is uniform below q, 1 lands just under q, 2 just above zero
    function automatic coeff_t draw_coeff(input int mode);
        logic [31:0] r;
        r = next_rand() >> 4;
        case (mode)
            1:       return coeff_t'(Q - 1 - (r % 1024));
            2:       return coeff_t'(r % 1024);
            default: return coeff_t'(r % Q);
        endcase
    endfunction

    function automatic pwo_cmd_t random_cmd(input pwo_op_e op, input logic acc);
        pwo_cmd_t c;
        c.op     = op;
        c.acc    = acc;
        // Disjoint regions so no command reads what it writes
        c.a_base = mem_addr_t'((next_rand() >> 8) % 32'h1f00);
        c.b_base = mem_addr_t'(32'h2000 + (next_rand() >> 8) % 32'h1f00);
        c.c_base = mem_addr_t'(32'h4000 + (next_rand() >> 8) % 32'h3f00);
        return c;
    endfunction

    task automatic fill_polys(input pwo_cmd_t c, input int a_mode, input int b_mode);
        mem_word_t wa;
        mem_word_t wb;
        mem_word_t wc;
        for (int k = 0; k < `PWO_WORDS; k++) begin
            for (int l = 0; l < `PWO_LANES; l++) begin
                wa[l] = `PWO_REG_W'(draw_coeff(a_mode));
                wb[l] = `PWO_REG_W'(draw_coeff(b_mode));
                wc[l] = `PWO_REG_W'(draw_coeff(0));
            end
            a_mem[mem_addr_t'(c.a_base + k)] = wa;
            b_mem[mem_addr_t'(c.b_base + k)] = wb;
            c_mem[mem_addr_t'(c.c_base + k)] = wc;
        end
    endtask

    function automatic coeff_t model_coeff(input pwo_cmd_t c, input coeff_t a,
                                           input coeff_t b, input coeff_t old);
        longint r;
        case (c.op)
            PWM:     r = (longint'(a) * longint'(b) + (c.acc ? longint'(old) : 0)) % Q;
            PWA:     r = (longint'(a) + longint'(b)) % Q;
            PWS:     r = (longint'(a) - longint'(b) + Q) % Q;
            default: r = 0;
        endcase
        return coeff_t'(r);
    endfunction

    // ====================
    // Checks
    // ====================

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_idle_outputs();
        check_value("cmd_ack_o", cmd_ack, 0);
        check_value("busy_o", busy, 0);
        check_value("a_rd_req_o.en", a_rd_req.en, 0);
        check_value("b_rd_req_o.en", b_rd_req.en, 0);
        check_value("c_rd_req_o.en", c_rd_req.en, 0);
        check_value("c_wr_req_o.en", c_wr_req.en, 0);
    endtask

    // Full four-phase transaction, entered and left at a falling edge
    task automatic run_cmd(input pwo_cmd_t c, input int hold);
        mem_word_t exp_q [$];
        mem_word_t w;
        int        cycles;
        int        n_rd;
        mem_addr_t ca;
        n_rd = (c.op == IDLE) ? 0 : `PWO_WORDS;
        for (int k = 0; k < n_rd; k++) begin
            ca = mem_addr_t'(c.c_base + k);
            for (int l = 0; l < `PWO_LANES; l++) begin
                w[l] = `PWO_REG_W'(model_coeff(c,
                    a_mem[mem_addr_t'(c.a_base + k)][l][`PWO_COEFF_W-1:0],
                    b_mem[mem_addr_t'(c.b_base + k)][l][`PWO_COEFF_W-1:0],
                    c_mem[ca][l][`PWO_COEFF_W-1:0]));
            end
            exp_q.push_back(w);
        end
        a_rd_cnt = 0;
        b_rd_cnt = 0;
        c_rd_cnt = 0;
        wr_addr_q.delete();
        wr_data_q.delete();
        @(posedge clk);
        cmd_req <= 1'b1;
        cmd     <= c;
        cycles = 0;
        @(negedge clk);
        while (!busy) begin
            check_value("cmd_ack_o", cmd_ack, 0);
            cycles++;
            if (cycles > 4) begin
                $display("Error: command was not accepted within 4 cycles of the request");
                $display("RESULT: FAIL");
                $fatal(1, "command not accepted");
            end
            @(negedge clk);
        end
        cycles = 0;
        while (!cmd_ack) begin
            check_value("busy_o", busy, 1);
            @(negedge clk);
            cycles++;
        end
        check_value("busy_o", busy, 0);
        check_value("cmd_ack_o latency", cycles, (c.op == IDLE) ? 1 : RUN_CYCLES);
        // Ack holds while req stays high, and nothing new starts
        repeat (hold) begin
            @(negedge clk);
            check_value("cmd_ack_o", cmd_ack, 1);
            check_value("busy_o", busy, 0);
        end
        @(posedge clk);
        cmd_req <= 1'b0;
        @(negedge clk);
        check_value("cmd_ack_o", cmd_ack, 1);
        @(negedge clk);
        check_value("cmd_ack_o", cmd_ack, 0);
        check_value("busy_o", busy, 0);
        check_value("a_rd_req_o count", a_rd_cnt, n_rd);
        check_value("b_rd_req_o count", b_rd_cnt, n_rd);
        check_value("c_rd_req_o count", c_rd_cnt, (c.op == PWM && c.acc) ? n_rd : 0);
        check_value("c_wr_req_o count", wr_addr_q.size(), n_rd);
        for (int k = 0; k < wr_addr_q.size(); k++) begin
            check_value($sformatf("c_wr_req_o.addr word %0d", k), wr_addr_q[k],
                        mem_addr_t'(c.c_base + k));
            for (int l = 0; l < `PWO_LANES; l++) begin
                check_value($sformatf("c_wr_data_o word %0d lane %0d", k, l),
                            wr_data_q[k][l], exp_q[k][l]);
            end
        end
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        pwo_cmd_t c;
        rand_state = 32'hf201;
        reset_n    = 1'b0;
        cmd_req    = 1'b0;
        cmd        = '0;
        a_rd_data  = '0;
        b_rd_data  = '0;
        c_rd_data  = '0;
        a_rd_cnt   = 0;
        b_rd_cnt   = 0;
        c_rd_cnt   = 0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_idle_outputs();

        // IDLE is acknowledged with no memory traffic
        c = random_cmd(IDLE, 1'b0);
        run_cmd(c, 1);

        c = random_cmd(PWM, 1'b0);
        fill_polys(c, 0, 0);
        run_cmd(c, 0);

        c = random_cmd(PWM, 1'b1);
        fill_polys(c, 0, 0);
        run_cmd(c, 2);

        // Sums at or above q
        c = random_cmd(PWA, 1'b0);
        fill_polys(c, 1, 1);
        run_cmd(c, 1);

        // Differences below zero
        c = random_cmd(PWS, 1'b0);
        fill_polys(c, 2, 1);
        run_cmd(c, 3);

        for (int i = 5; i < NUM_CMDS; i++) begin
            c = random_cmd(pwo_op_e'((next_rand() >> 16) % 4), 1'((next_rand() >> 20) % 2));
            fill_polys(c, 0, 0);
            run_cmd(c, i % 4);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/pwo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwo_params.svh"

module pwo_top (
    input  wire                    clk,
    input  wire                    reset_n,

    // Command handshake
    input  wire                    cmd_req_i,
    input  wire pwo_mem_pkg::pwo_cmd_t cmd_i,
    output logic                   cmd_ack_o,
    output logic                   busy_o,

    // Memory requests
    output pwo_mem_pkg::mem_req_t  a_rd_req_o,
    output pwo_mem_pkg::mem_req_t  b_rd_req_o,
    output pwo_mem_pkg::mem_req_t  c_rd_req_o,
    output pwo_mem_pkg::mem_req_t  c_wr_req_o,

    // Memory data
    input  wire pwo_mem_pkg::mem_word_t a_rd_data_i,
    input  wire pwo_mem_pkg::mem_word_t b_rd_data_i,
    input  wire pwo_mem_pkg::mem_word_t c_rd_data_i,
    output pwo_mem_pkg::mem_word_t c_wr_data_o
);
    import pwo_mem_pkg::*;

    pwo_cmd_t cfg;
    logic     start;
    logic     done;

    // Command capture and handshake
    pwo_cfg_regs cfg_regs_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_req_i (cmd_req_i),
        .cmd_i     (cmd_i),
        .done_i    (done),
        .cfg_o     (cfg),
        .start_o   (start),
        .cmd_ack_o (cmd_ack_o),
        .busy_o    (busy_o)
    );

    // Address sequencing and write alignment
    pwo_ctrl ctrl_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .cfg_i      (cfg),
        .start_i    (start),
        .a_rd_req_o (a_rd_req_o),
        .b_rd_req_o (b_rd_req_o),
        .c_rd_req_o (c_rd_req_o),
        .c_wr_req_o (c_wr_req_o),
        .done_o     (done)
    );

    // Four coefficient lanes
    pwo_datapath datapath_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .cfg_i       (cfg),
        .a_rd_data_i (a_rd_data_i),
        .b_rd_data_i (b_rd_data_i),
        .c_rd_data_i (c_rd_data_i),
        .c_wr_data_o (c_wr_data_o)
    );

endmodule

`default_nettype wire

//--- design/pwo_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwo_params.svh"

module pwo_cfg_regs (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    cmd_req_i,
    input  wire pwo_mem_pkg::pwo_cmd_t cmd_i,
    input  wire                    done_i,
    output pwo_mem_pkg::pwo_cmd_t  cfg_o,
    output logic                   start_o,
    output logic                   cmd_ack_o,
    output logic                   busy_o
);
    import pwo_arith_pkg::*;
    import pwo_mem_pkg::*;

    typedef enum logic [1:0] {
        WAIT_REQ,
        RUN,
        ACK,
        WAIT_DROP
    } hs_state_e;

    hs_state_e state_q;
    pwo_cmd_t  cmd_q;
    logic      accept;
    logic      finish;

    // Accept only with both req high and ack low
    assign accept = (state_q == WAIT_REQ) && cmd_req_i && !cmd_ack_o;

    // An IDLE command is acknowledged without starting the controller
    assign finish = (state_q == RUN) && (done_i || (cmd_q.op == IDLE));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= WAIT_REQ;
            cmd_q     <= '0;
            start_o   <= 1'b0;
            cmd_ack_o <= 1'b0;
            busy_o    <= 1'b0;
        end else begin
            start_o <= accept && (cmd_i.op != IDLE);
            case (state_q)
                WAIT_REQ: begin
                    if (accept) begin
                        state_q <= RUN;
                        cmd_q   <= cmd_i;
                        busy_o  <= 1'b1;
                    end
                end
                RUN: begin
                    if (finish) begin
                        state_q   <= ACK;
                        busy_o    <= 1'b0;
                        cmd_ack_o <= 1'b1;
                    end
                end
                ACK: begin
                    if (!cmd_req_i) begin
                        state_q   <= WAIT_DROP;
                        cmd_ack_o <= 1'b0;
                    end
                end
                // One turnaround cycle before the next command
                WAIT_DROP: state_q <= WAIT_REQ;
                default:   state_q <= WAIT_REQ;
            endcase
        end
    end

    assign cfg_o = cmd_q;

    done_in_run: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |-> (state_q == RUN));

    cmd_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (cmd_req_i && !cmd_ack_o) ##1 (cmd_req_i && !cmd_ack_o) |-> $stable(cmd_i));

endmodule

`default_nettype wire

//--- design/pwo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwo_params.svh"

module pwo_ctrl (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire pwo_mem_pkg::pwo_cmd_t cfg_i,
    input  wire                    start_i,
    output pwo_mem_pkg::mem_req_t  a_rd_req_o,
    output pwo_mem_pkg::mem_req_t  b_rd_req_o,
    output pwo_mem_pkg::mem_req_t  c_rd_req_o,
    output pwo_mem_pkg::mem_req_t  c_wr_req_o,
    output logic                   done_o
);
    import pwo_arith_pkg::*;
    import pwo_mem_pkg::*;

    localparam int CNT_W = $clog2(`PWO_WORDS);

    // Write request plus a marker for the final word
    typedef struct packed {
        logic     last;
        mem_req_t req;
    } wr_slot_t;

    logic                    rd_run;
    logic [CNT_W-1:0]        word_cnt;
    logic                    last_word;
    logic                    acc_rd;
    mem_addr_t               offset;
    mem_addr_t               c_addr;
    wr_slot_t                wr_slot_in;
    wr_slot_t [`PWO_LAT-1:0] wr_pipe;

    assign last_word = (word_cnt == CNT_W'(`PWO_WORDS - 1));
    assign acc_rd    = (cfg_i.op == PWM) && cfg_i.acc;
    assign offset    = mem_addr_t'(word_cnt);
    assign c_addr    = cfg_i.c_base + offset;

    // ====================
    // Read sequencing
    // ====================

    // One word per cycle, starting the cycle after start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_run   <= 1'b0;
            word_cnt <= '0;
        end else if (start_i) begin
            rd_run   <= 1'b1;
            word_cnt <= '0;
        end else if (rd_run) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
                rd_run <= 1'b0;
            end
        end
    end

    assign a_rd_req_o = '{en: rd_run, addr: cfg_i.a_base + offset};
    assign b_rd_req_o = '{en: rd_run, addr: cfg_i.b_base + offset};

    // Old C words are only needed when accumulating
    assign c_rd_req_o = '{en: rd_run && acc_rd, addr: c_addr};

    // ====================
    // Write alignment
    // ====================

    assign wr_slot_in = '{last: last_word, req: '{en: rd_run, addr: c_addr}};

    // Write k leaves the pipe PWO_LAT cycles after read k
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_pipe <= '0;
            done_o  <= 1'b0;
        end else begin
            wr_pipe <= {wr_pipe[`PWO_LAT-2:0], wr_slot_in};
            done_o  <= wr_pipe[`PWO_LAT-1].req.en && wr_pipe[`PWO_LAT-1].last;
        end
    end

    assign c_wr_req_o = wr_pipe[`PWO_LAT-1].req;

    c_rd_only_acc: assert property (@(posedge clk) disable iff (!reset_n)
        c_rd_req_o.en |-> a_rd_req_o.en && (cfg_i.op == PWM) && cfg_i.acc);

endmodule

`default_nettype wire

//--- pwo_datapath/pwo_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwo_params.svh"

module pwo_datapath (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire pwo_mem_pkg::pwo_cmd_t  cfg_i,
    input  wire pwo_mem_pkg::mem_word_t a_rd_data_i,
    input  wire pwo_mem_pkg::mem_word_t b_rd_data_i,
    input  wire pwo_mem_pkg::mem_word_t c_rd_data_i,
    output pwo_mem_pkg::mem_word_t  c_wr_data_o
);
    import pwo_arith_pkg::*;
    import pwo_mem_pkg::*;

    coeff_vec_t a_vec;
    coeff_vec_t b_vec;
    coeff_vec_t c_vec;
    coeff_vec_t r_vec;
    logic       acc_en;

    assign acc_en = (cfg_i.op == PWM) && cfg_i.acc;

    // ====================
    // Unpack
    // ====================

    // Read data lands one cycle after the request
    always_comb begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            a_vec[i] = a_rd_data_i[i][`PWO_COEFF_W-1:0];
            b_vec[i] = b_rd_data_i[i][`PWO_COEFF_W-1:0];
            // C term is zero unless the old C contents were read
            c_vec[i] = acc_en ? c_rd_data_i[i][`PWO_COEFF_W-1:0] : '0;
        end
    end

    // ====================
    // Lanes
    // ====================

    // Two lane stages bring the result in line with the write request
    for (genvar i = 0; i < `PWO_LANES; i++) begin : g_lane
        pwo_lane lane_inst (
            .clk     (clk),
            .reset_n (reset_n),
            .op_i    (cfg_i.op),
            .a_i     (a_vec[i]),
            .b_i     (b_vec[i]),
            .c_i     (c_vec[i]),
            .res_o   (r_vec[i])
        );
    end

    // ====================
    // Repack
    // ====================

    always_comb begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            c_wr_data_o[i] = `PWO_REG_W'(r_vec[i]);
        end
    end

endmodule

`default_nettype wire

//--- pwo_datapath/pwo_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwo_params.svh"

module pwo_lane (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire pwo_arith_pkg::pwo_op_e op_i,
    input  wire pwo_arith_pkg::coeff_t  a_i,
    input  wire pwo_arith_pkg::coeff_t  b_i,
    input  wire pwo_arith_pkg::coeff_t  c_i,
    output pwo_arith_pkg::coeff_t   res_o
);
    import pwo_arith_pkg::*;

    localparam int W = `PWO_COEFF_W;

    // 2^23 = 2^13 - 1 mod q
    localparam int FOLD_SH = 13;

    prod_t       s1_q;
    coeff_t      c_q;
    coeff_t      res_q;
    logic [36:0] fold1;
    logic [27:0] fold2;
    logic [23:0] fold3;

    // ====================
    // Stage 1
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_q <= '0;
            c_q  <= '0;
        end else begin
            case (op_i)
                PWM:     s1_q <= prod_t'(a_i) * prod_t'(b_i);
                PWA:     s1_q <= prod_t'(a_i) + prod_t'(b_i);
                // Offset by q so the difference stays positive
                PWS:     s1_q <= prod_t'(a_i) + prod_t'(`PWO_Q) - prod_t'(b_i);
                default: s1_q <= '0;
            endcase
            c_q <= c_i;
        end
    end

    // ====================
    // Stage 2
    // ====================

    // Three folds of the bits above 2^23, the C term joins before the last
    always_comb begin
        fold1 = 37'(s1_q[W-1:0]) + (37'(s1_q[2*W-1:W]) << FOLD_SH) - 37'(s1_q[2*W-1:W]);
        fold2 = 28'(fold1[W-1:0]) + (28'(fold1[36:W]) << FOLD_SH) - 28'(fold1[36:W])
              + 28'(c_q);
        fold3 = 24'(fold2[W-1:0]) + (24'(fold2[27:W]) << FOLD_SH) - 24'(fold2[27:W]);
    end

    // fold3 is below 2q here
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_q <= '0;
        end else if (fold3 >= 24'(`PWO_Q)) begin
            res_q <= coeff_t'(fold3 - 24'(`PWO_Q));
        end else begin
            res_q <= coeff_t'(fold3);
        end
    end

    assign res_o = res_q;

    res_below_q: assert property (@(posedge clk) disable iff (!reset_n)
        res_o < `PWO_Q);

endmodule

`default_nettype wire

//--- common/pwo_mem_pkg.sv
`default_nettype none

`include "pwo_params.svh"

package pwo_mem_pkg;

    // ====================
    // Memory interface
    // ====================

    typedef logic [`PWO_ADDR_W-1:0] mem_addr_t;

    // Four 24-bit slots, each holding a coefficient with a zero top bit
    typedef logic [`PWO_LANES-1:0][`PWO_REG_W-1:0] mem_word_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_req_t;

    // ====================
    // Command
    // ====================

    typedef struct packed {
        pwo_arith_pkg::pwo_op_e op;
        logic                   acc;
        mem_addr_t              a_base;
        mem_addr_t              b_base;
        mem_addr_t              c_base;
    } pwo_cmd_t;

endpackage

`default_nettype wire

//--- common/pwo_arith_pkg.sv
`default_nettype none

`include "pwo_params.svh"

package pwo_arith_pkg;

    // ====================
    // Coefficient types
    // ====================

    // One coefficient, kept below q
    typedef logic [`PWO_COEFF_W-1:0] coeff_t;

    // Full width of a coefficient product
    typedef logic [2*`PWO_COEFF_W-1:0] prod_t;

    // All lanes of one memory word, lane 0 in the low bits
    typedef coeff_t [`PWO_LANES-1:0] coeff_vec_t;

    // ====================
    // Opcodes
    // ====================

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        PWM  = 2'd1,
        PWA  = 2'd2,
        PWS  = 2'd3
    } pwo_op_e;

endpackage

`default_nettype wire

//--- common/pwo_params.svh
`ifndef PWO_PARAMS_SVH
`define PWO_PARAMS_SVH

// ML-DSA modulus, q = 2^23 - 2^13 + 1
`define PWO_Q 23'd8380417

// Coefficient width and its slot in a memory word
`define PWO_COEFF_W 23
`define PWO_REG_W 24

// Four coefficients per word, 256 per polynomial
`define PWO_LANES 4
`define PWO_WORDS 64

`define PWO_ADDR_W 15

// Cycles from a read request to the matching write request
`define PWO_LAT 3

`endif
